// File: hw/flow_control_pkg.sv
// Shared sizes and encodings; config_addr_bound assumes config_entries = 2 and branch_count >= 2
`default_nettype none

package flow_control_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------

    localparam int branch_count       = 4;
    localparam int branch_index_width = $clog2(branch_count);
    localparam int thread_count       = 4;
    localparam int thread_width       = 2;
    // Must stay below thread_count so a thread sees its own update
    localparam int fetch_depth        = 2;
    localparam int pc_width           = 10;
    localparam int word_width         = 32;
    localparam int addr_width         = 10;

    // Offset 0 holds the target word, offset 1 the condition word
    localparam int config_entries     = 2;

    localparam logic [addr_width-1:0] config_addr_base  = 10'h200;
    localparam logic [addr_width-1:0] config_addr_bound =
        config_addr_base + addr_width'(branch_count * config_entries - 1);

    typedef logic [pc_width-1:0]     pc_t;
    typedef logic [thread_width-1:0] thread_t;

    // ------------------------------------------------------------
    // Branch condition select
    // ------------------------------------------------------------

    typedef enum logic [2:0] {
        cond_never      = 3'd0,
        cond_always     = 3'd1,
        cond_a_negative = 3'd2,
        cond_a_carryout = 3'd3,
        cond_a_external = 3'd4,
        cond_b_lessthan = 3'd5,
        cond_b_external = 3'd6,
        cond_r_zero     = 3'd7
    } cond_sel_e;

    // ------------------------------------------------------------
    // Configuration word, decoded by address offset
    // ------------------------------------------------------------

    typedef struct packed {
        logic [word_width-2*pc_width-1:0] unused;
        pc_t                              origin;
        pc_t                              destination;
    } config_target_t;

    typedef struct packed {
        logic [word_width-6:0] unused;
        logic                  cancel_en;
        logic                  invert;
        cond_sel_e             cond_sel;
    } config_cond_t;

    typedef union packed {
        config_target_t target;
        config_cond_t   cond;
    } config_word_u;

endpackage

`default_nettype wire

// File: hw/branch_unit.sv
// One shared configuration for all threads; origin and destination are undefined until written
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire logic                                    clock,
    input  wire logic                                    reset,
    input  wire logic                                    config_wren,
    input  wire logic                                    select,
    input  wire logic                                    offset,
    input  wire flow_control_pkg::config_word_u          config_data,
    input  wire flow_control_pkg::pc_t                   pc_current,
    input  wire logic                                    a_negative,
    input  wire logic                                    a_carryout,
    input  wire logic                                    a_external,
    input  wire logic                                    b_lessthan,
    input  wire logic                                    b_external,
    input  wire logic [flow_control_pkg::word_width-1:0] r_previous,
    output logic                                         jump,
    output logic                                         cancel_req,
    output flow_control_pkg::pc_t                        destination
);

    import flow_control_pkg::*;

    pc_t       origin;
    cond_sel_e cond_sel;
    logic      invert;
    logic      cancel_en;
    logic      cond_raw;
    logic      origin_hit;
    logic      target_wren;
    logic      cond_wren;

    // ------------------------------------------------------------
    // Configuration registers
    // ------------------------------------------------------------

    assign target_wren = config_wren && select && !offset;
    assign cond_wren   = config_wren && select && offset;

    // Target word: where the branch sits and where it goes
    always_ff @(posedge clock) begin
        if (target_wren) begin
            origin      <= config_data.target.origin;
            destination <= config_data.target.destination;
        end
    end

    // Condition word
    always_ff @(posedge clock) begin
        if (reset) begin
            cond_sel  <= cond_never;
            invert    <= 1'b0;
            cancel_en <= 1'b0;
        end else if (cond_wren) begin
            cond_sel  <= config_data.cond.cond_sel;
            invert    <= config_data.cond.invert;
            cancel_en <= config_data.cond.cancel_en;
        end
    end

    // ------------------------------------------------------------
    // Branch evaluation against the returning pc
    // ------------------------------------------------------------

    always_comb begin
        case (cond_sel)
            cond_never: begin
                cond_raw = 1'b0;
            end
            cond_always: begin
                cond_raw = 1'b1;
            end
            cond_a_negative: begin
                cond_raw = a_negative;
            end
            cond_a_carryout: begin
                cond_raw = a_carryout;
            end
            cond_a_external: begin
                cond_raw = a_external;
            end
            cond_b_lessthan: begin
                cond_raw = b_lessthan;
            end
            cond_b_external: begin
                cond_raw = b_external;
            end
            cond_r_zero: begin
                cond_raw = (r_previous == '0);
            end
            default: begin
                cond_raw = 1'b0;
            end
        endcase
    end

    assign origin_hit = (origin == pc_current);

    // Inverting cond_never gives an unconditional branch as well
    assign jump       = origin_hit && (cond_raw ^ invert);
    assign cancel_req = jump && cancel_en;

endmodule

`default_nettype wire

// File: hw/branch_arbiter.sv
// Purely combinational; destination reads as zero when no branch fires
`timescale 1ns/1ps
`default_nettype none

module branch_arbiter (
    input  wire logic [flow_control_pkg::branch_count-1:0] jumps,
    input  wire logic [flow_control_pkg::branch_count-1:0] cancel_reqs,
    input  wire flow_control_pkg::pc_t                     destinations
                                                           [flow_control_pkg::branch_count],
    output logic                                           jump,
    output logic                                           cancel,
    output flow_control_pkg::pc_t                          jump_destination
);

    import flow_control_pkg::*;

    // ------------------------------------------------------------
    // Fixed priority, lowest index wins
    // ------------------------------------------------------------

    // Scan from the top so the lowest firing index is the last to land
    always_comb begin
        jump             = 1'b0;
        cancel           = 1'b0;
        jump_destination = '0;
        for (int i = branch_count - 1; i >= 0; i--) begin
            if (jumps[i]) begin
                jump             = 1'b1;
                cancel           = cancel_reqs[i];
                jump_destination = destinations[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/pc_controller.sv
// No stall input; a thread's update lands before its reissue only while thread_count > fetch_depth
`timescale 1ns/1ps
`default_nettype none

module pc_controller (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      jump,
    input  wire flow_control_pkg::pc_t     jump_destination,
    input  wire flow_control_pkg::pc_t     pc_current,
    input  wire flow_control_pkg::thread_t thread_current,
    output flow_control_pkg::pc_t          pc,
    output flow_control_pkg::thread_t      thread
);

    import flow_control_pkg::*;

    pc_t     pc_regs [thread_count];
    thread_t thread_ptr;
    thread_t thread_ptr_next;
    pc_t     pc_next;

    // ------------------------------------------------------------
    // Round-robin thread pointer
    // ------------------------------------------------------------

    assign thread_ptr_next = (thread_ptr == thread_t'(thread_count - 1)) ?
                             '0 : thread_ptr + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            thread_ptr <= '0;
        end else begin
            thread_ptr <= thread_ptr_next;
        end
    end

    // ------------------------------------------------------------
    // Per-thread pc update on return
    // ------------------------------------------------------------

    // Sequential pc wraps at the top of the pc space
    assign pc_next = jump ? jump_destination : pc_current + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < thread_count; i++) begin
                pc_regs[i] <= '0;
            end
        end else begin
            pc_regs[thread_current] <= pc_next;
        end
    end

    // Issue side reads the register of the thread being fetched
    assign pc     = pc_regs[thread_ptr];
    assign thread = thread_ptr;

endmodule

`default_nettype wire

// File: hw/fetch_delay_line.sv
// depth must be at least 1; every stage clears to zero on reset
`timescale 1ns/1ps
`default_nettype none

module fetch_delay_line #(
    parameter int depth = flow_control_pkg::fetch_depth,
    parameter int width = flow_control_pkg::pc_width + flow_control_pkg::thread_width
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic [width-1:0] in,
    output logic      [width-1:0] out
);

    logic [width-1:0] stages [depth];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign out = stages[depth-1];

endmodule

`default_nettype wire

// File: hw/flow_control.sv
// Writes qualify on the previous instruction only; never stalls, pc advances one thread per cycle
`timescale 1ns/1ps
`default_nettype none

module flow_control (
    input  wire logic                                    clock,
    input  wire logic                                    reset,
    input  wire logic                                    ior_previous,
    input  wire logic                                    cancel_previous,
    input  wire logic                                    a_negative,
    input  wire logic                                    a_carryout,
    input  wire logic                                    a_external,
    input  wire logic                                    b_lessthan,
    input  wire logic                                    b_external,
    input  wire logic [flow_control_pkg::word_width-1:0] r_previous,
    input  wire logic [flow_control_pkg::addr_width-1:0] config_addr,
    input  wire flow_control_pkg::config_word_u          config_data,
    output flow_control_pkg::pc_t                        pc,
    output logic                                         cancel
);

    import flow_control_pkg::*;

    logic                          config_hit;
    logic                          config_wren;
    logic [addr_width-1:0]         config_addr_translated;
    logic [branch_index_width-1:0] config_branch;
    logic                          config_offset;

    logic [branch_count-1:0]       jumps;
    logic [branch_count-1:0]       cancel_reqs;
    pc_t                           destinations [branch_count];
    logic                          jump;
    pc_t                           jump_destination;

    thread_t                       thread;
    pc_t                           pc_current;
    thread_t                       thread_current;

    // ------------------------------------------------------------
    // Configuration address decode
    // ------------------------------------------------------------

    assign config_hit  = (config_addr >= config_addr_base) && (config_addr <= config_addr_bound);

    // An annulled I/O instruction must not reconfigure anything
    assign config_wren = ior_previous && !cancel_previous && config_hit;

    assign config_addr_translated = config_addr - config_addr_base;
    assign config_branch = branch_index_width'(config_addr_translated / config_entries);
    assign config_offset = config_addr_translated[0];

    // ------------------------------------------------------------
    // Parallel branch units, mapped consecutively
    // ------------------------------------------------------------

    for (genvar i = 0; i < branch_count; i++) begin : gen_branch
        branch_unit branch_unit_i (
            .clock       (clock),
            .reset       (reset),
            .config_wren (config_wren),
            .select      (config_branch == branch_index_width'(i)),
            .offset      (config_offset),
            .config_data (config_data),
            .pc_current  (pc_current),
            .a_negative  (a_negative),
            .a_carryout  (a_carryout),
            .a_external  (a_external),
            .b_lessthan  (b_lessthan),
            .b_external  (b_external),
            .r_previous  (r_previous),
            .jump        (jumps[i]),
            .cancel_req  (cancel_reqs[i]),
            .destination (destinations[i])
        );
    end

    branch_arbiter branch_arbiter_i (
        .jumps            (jumps),
        .cancel_reqs      (cancel_reqs),
        .destinations     (destinations),
        .jump             (jump),
        .cancel           (cancel),
        .jump_destination (jump_destination)
    );

    // ------------------------------------------------------------
    // Pc issue and its return after the fetch latency
    // ------------------------------------------------------------

    pc_controller pc_controller_i (
        .clock            (clock),
        .reset            (reset),
        .jump             (jump),
        .jump_destination (jump_destination),
        .pc_current       (pc_current),
        .thread_current   (thread_current),
        .pc               (pc),
        .thread           (thread)
    );

    // Pc and thread number travel side by side
    fetch_delay_line #(
        .depth (fetch_depth),
        .width (pc_width + thread_width)
    ) fetch_delay_line_i (
        .clock (clock),
        .reset (reset),
        .in    ({pc, thread}),
        .out   ({pc_current, thread_current})
    );

endmodule

`default_nettype wire

// File: verif/flow_control_sva.sv
// Bound into flow_control; the next-pc rule starts once the fetch pipeline holds real issues
`timescale 1ns/1ps
`default_nettype none

module flow_control_sva (
    input wire logic                  clock,
    input wire logic                  reset,
    input wire flow_control_pkg::pc_t pc,
    input wire logic                  cancel,
    input wire flow_control_pkg::pc_t pc_current,
    input wire logic                  jump,
    input wire flow_control_pkg::pc_t jump_destination
);

    import flow_control_pkg::*;

    localparam int reissue_gap = thread_count - fetch_depth;

    int settle_count;
    // Number of assertion failures so far
    int failure_count = 0;

    always_ff @(posedge clock) begin
        if (reset) begin
            settle_count <= 0;
        end else if (settle_count < thread_count) begin
            settle_count <= settle_count + 1;
        end
    end

    assert property (@(posedge clock) $fell(reset) |-> !cancel)
        else begin
            failure_count++;
            $error("cancel high in the first cycle after reset");
        end

    assert property (@(posedge clock) disable iff (reset) !$isunknown(pc))
        else begin
            failure_count++;
            $error("pc is unknown");
        end

    // The returning thread is issued again reissue_gap cycles later
    assert property (@(posedge clock) disable iff (reset)
        settle_count >= thread_count |->
            (pc == pc_t'($past(pc_current, reissue_gap) + 1'b1)) ||
            ($past(jump, reissue_gap) && pc == $past(jump_destination, reissue_gap)))
        else begin
            failure_count++;
            $error("next issued pc is neither sequential nor a branch destination");
        end

endmodule

bind flow_control flow_control_sva flow_control_sva_i (
    .clock            (clock),
    .reset            (reset),
    .pc               (pc),
    .cancel           (cancel),
    .pc_current       (pc_current),
    .jump             (jump),
    .jump_destination (jump_destination)
);

`default_nettype wire

// File: verif/flow_control_model.svh
// Reference model for the testbench; a branch's target word must be written before its condition word
`ifndef flow_control_model_svh
`define flow_control_model_svh

// Copy of the branch configuration registers
pc_t       cfg_origin      [branch_count];
pc_t       cfg_destination [branch_count];
cond_sel_e cfg_cond_sel    [branch_count];
logic      cfg_invert      [branch_count];
logic      cfg_cancel_en   [branch_count];

// Per-thread pcs, issue pointer and the fetch pipeline
pc_t       thread_pc   [thread_count];
pc_t       pipe_pc     [fetch_depth];
int        pipe_thread [fetch_depth];
int        issue_ptr;

// Decision for the pc returning in the current cycle
logic      exp_jump;
logic      exp_cancel;
pc_t       exp_destination;

function automatic void reset_model();
    for (int i = 0; i < branch_count; i++) begin
        cfg_cond_sel[i]  = cond_never;
        cfg_invert[i]    = 1'b0;
        cfg_cancel_en[i] = 1'b0;
    end
    thread_pc   = '{default: '0};
    pipe_pc     = '{default: '0};
    pipe_thread = '{default: 0};
    issue_ptr   = 0;
endfunction

// Flags ordered a_negative, a_carryout, a_external, b_lessthan, b_external
function automatic logic condition_holds(cond_sel_e sel, logic [4:0] flags, logic r_zero);
    logic [7:0] by_code;
    // Indexed by condition code, never at bit 0 and r_zero at bit 7
    by_code = {r_zero, flags[0], flags[1], flags[2], flags[3], flags[4], 1'b1, 1'b0};
    return by_code[sel];
endfunction

function automatic void predict_branch(logic [4:0] flags, logic r_zero);
    exp_jump        = 1'b0;
    exp_cancel      = 1'b0;
    exp_destination = '0;
    for (int i = 0; i < branch_count; i++) begin
        if (!exp_jump && cfg_origin[i] == pipe_pc[fetch_depth-1] &&
                condition_holds(cfg_cond_sel[i], flags, r_zero) != cfg_invert[i]) begin
            exp_jump        = 1'b1;
            exp_cancel      = cfg_cancel_en[i];
            exp_destination = cfg_destination[i];
        end
    end
endfunction

// One clock edge: retire the returning pc, issue the next thread, apply a write
function automatic void advance_model(logic ior, logic cancel_prev,
                                      logic [addr_width-1:0] addr, config_word_u data);
    int  branch;
    pc_t issued;
    issued = thread_pc[issue_ptr];
    thread_pc[pipe_thread[fetch_depth-1]] =
        exp_jump ? exp_destination : pc_t'(pipe_pc[fetch_depth-1] + 1'b1);
    for (int s = fetch_depth - 1; s > 0; s--) begin
        pipe_pc[s]     = pipe_pc[s-1];
        pipe_thread[s] = pipe_thread[s-1];
    end
    pipe_pc[0]     = issued;
    pipe_thread[0] = issue_ptr;
    issue_ptr      = (issue_ptr + 1) % thread_count;
    if (ior && !cancel_prev && addr >= config_addr_base && addr <= config_addr_bound) begin
        branch = (addr - config_addr_base) / config_entries;
        if ((addr - config_addr_base) % config_entries == 0) begin
            cfg_origin[branch]      = data.target.origin;
            cfg_destination[branch] = data.target.destination;
        end else begin
            cfg_cond_sel[branch]  = data.cond.cond_sel;
            cfg_invert[branch]    = data.cond.invert;
            cfg_cancel_en[branch] = data.cond.cancel_en;
        end
    end
endfunction

`endif

// File: verif/flow_control_tb.sv
// Random stimulus from seed 1; branch 3 is kept as a loop back to pc 0 so threads stay in a small range
`timescale 1ns/1ps
`default_nettype none

module flow_control_tb;

    import flow_control_pkg::*;

    localparam int  test_cycles    = 2000;
    localparam int  timeout_cycles = 2100;
    localparam int  idle_cycles    = 20;
    // Highest pc a thread reaches before branch 3 sends it back
    localparam pc_t loop_origin    = pc_t'(32);

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  ior_previous;
    logic                  cancel_previous;
    logic                  a_negative;
    logic                  a_carryout;
    logic                  a_external;
    logic                  b_lessthan;
    logic                  b_external;
    logic [word_width-1:0] r_previous;
    logic [addr_width-1:0] config_addr;
    config_word_u          config_data;
    pc_t                   pc;
    logic                  cancel;
    int                    cycle_count = 0;
    int                    seed = 1;

    `include "flow_control_model.svh"

    flow_control flow_control_i (
        .clock           (clock),
        .reset           (reset),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .a_negative      (a_negative),
        .a_carryout      (a_carryout),
        .a_external      (a_external),
        .b_lessthan      (b_lessthan),
        .b_external      (b_external),
        .r_previous      (r_previous),
        .config_addr     (config_addr),
        .config_data     (config_data),
        .pc              (pc),
        .cancel          (cancel)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------

    task automatic check_pc(input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            $display("ERR t=%0t pc expected %0d actual %0d", $time, expected, actual);
            $display("Checks failed");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_cancel(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR t=%0t cancel expected %b actual %b", $time, expected, actual);
            $display("Checks failed");
            $fatal(1, "cancel mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    task automatic drive_random_flags();
        a_negative = 1'($urandom);
        a_carryout = 1'($urandom);
        a_external = 1'($urandom);
        b_lessthan = 1'($urandom);
        b_external = 1'($urandom);
        // Zero often enough to exercise cond_r_zero
        r_previous = ($urandom % 4 == 0) ? '0 : $urandom;
    endtask

    // Low five bits double as cond_sel, invert and cancel_en
    function automatic config_word_u random_config_word();
        config_word_u word;
        word = config_word_u'($urandom);
        word.target.origin      = pc_t'($urandom % loop_origin);
        word.target.destination = pc_t'($urandom % loop_origin);
        return word;
    endfunction

    function automatic logic [addr_width-1:0] random_outside_addr();
        logic [addr_width-1:0] addr;
        addr = addr_width'($urandom);
        if ($urandom % 2) begin
            addr = ($urandom % 2) ? config_addr_base - addr_width'(1 + $urandom % 4) :
                                    config_addr_bound + addr_width'(1 + $urandom % 4);
        end else if (addr >= config_addr_base && addr <= config_addr_bound) begin
            addr = addr ^ config_addr_base;
        end
        return addr;
    endfunction

    // Inside hits go to branches 0 to 2 only
    function automatic logic [addr_width-1:0] random_config_addr();
        if ($urandom % 2) begin
            return config_addr_base + addr_width'($urandom % ((branch_count - 1) * config_entries));
        end
        return random_outside_addr();
    endfunction

    // Called at a falling edge; returns at the next one
    task automatic run_cycle(input logic ior, input logic cancel_prev,
                             input logic [addr_width-1:0] addr, input config_word_u data);
        ior_previous    = ior;
        cancel_previous = cancel_prev;
        config_addr     = addr;
        config_data     = data;
        drive_random_flags();
        #1;
        predict_branch({a_negative, a_carryout, a_external, b_lessthan, b_external},
                       r_previous == '0);
        check_pc(thread_pc[issue_ptr], pc);
        check_cancel(exp_cancel, cancel);
        advance_model(ior, cancel_prev, addr, data);
        @(negedge clock);
    endtask

    initial begin
        config_word_u word;
        void'($urandom(seed));
        reset           = 1'b1;
        ior_previous    = 1'b0;
        cancel_previous = 1'b0;
        config_addr     = '0;
        config_data     = '0;
        drive_random_flags();
        reset_model();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // No configuration yet, writes are annulled or miss the window
        repeat (idle_cycles) run_cycle(1'($urandom), 1'b1, random_config_addr(),
                                       random_config_word());
        repeat (idle_cycles) run_cycle(1'b1, 1'b0, random_outside_addr(), random_config_word());
        // All target words first
        for (int i = 0; i < branch_count - 1; i++) begin
            run_cycle(1'b1, 1'b0, config_addr_base + addr_width'(i * config_entries),
                      random_config_word());
        end
        word = '0;
        word.target.origin = loop_origin;
        run_cycle(1'b1, 1'b0, config_addr_bound - 1'b1, word);
        word = '0;
        word.cond.cond_sel = cond_always;
        run_cycle(1'b1, 1'b0, config_addr_bound, word);
        while (cycle_count < test_cycles) begin
            run_cycle($urandom % 6 == 0, $urandom % 4 == 0, random_config_addr(),
                      random_config_word());
        end
        if (flow_control_i.flow_control_sva_i.failure_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verif
hw/flow_control_pkg.sv
hw/branch_unit.sv
hw/branch_arbiter.sv
hw/pc_controller.sv
hw/fetch_delay_line.sv
hw/flow_control.sv
verif/flow_control_sva.sv
verif/flow_control_tb.sv
